/* all.f */
+incdir+testbench
design/hdmi_eth_pkg.sv
design/sync_timing.sv
design/video_capture.sv
design/aux_capture.sv
design/word_fifo.sv
design/tx_arbiter.sv
design/frame_sender.sv
design/hdmi_eth_tx_top.sv
testbench/tb_top.sv

/* design/aux_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module aux_capture import hdmi_eth_pkg::*; (
	input  wire            clk50m_bufg,
	input  wire            RSTBTN,
	input  wire hdmi_in_t  hdmi_in,
	input  wire line_pos_t line_pos,
	output logic           wr_en,
	output aux_word_t      word
);

	logic             ade_q;                   // ade one cycle back
	logic             burst_first;             // First cycle of an ade burst
	logic [CNT_W-1:0] burst_hcnt;              // hcnt held for the rest of the burst
	logic [CNT_W-1:0] start_hcnt;

	assign burst_first = hdmi_in.ade & ~ade_q;

	// First cycle uses the live count, later cycles the held one
	assign start_hcnt = burst_first ? line_pos.hcnt : burst_hcnt;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			ade_q <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			ade_q <= hdmi_in.ade;
			wr_en <= hdmi_in.ade;              // One word per ade cycle
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		if (burst_first) begin
			burst_hcnt <= line_pos.hcnt;
		end
		if (hdmi_in.ade) begin
			word.hcnt <= start_hcnt;
			word.aux  <= hdmi_in.aux;
		end
	end

endmodule

`default_nettype wire

/* design/frame_sender.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sender import hdmi_eth_pkg::*; #(
	parameter int IFG_CYCLES = 2               // Idle cycles after each frame
) (
	input  wire           clk50m_bufg,
	input  wire           RSTBTN,
	input  wire           word_valid,
	input  wire tx_word_t word,
	output logic          word_ready,
	output logic          tx_en,
	output logic [7:0]    txd
);

	localparam int GAP_W  = (IFG_CYCLES > 2) ? $clog2(IFG_CYCLES) : 1;
	localparam int BCNT_W = $clog2(VIDEO_BYTES + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND,
		ST_GAP
	} state_t;

	state_t            state;
	logic [BCNT_W-1:0] byte_cnt;               // Payload bytes still to go
	logic [47:0]       shift;                  // Next byte in the top 8 bits
	logic [GAP_W-1:0]  gap_cnt;

	assign word_ready = (state == ST_IDLE);    // One word per frame

	//////////////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state    <= ST_IDLE;
			tx_en    <= 1'b0;
			txd      <= '0;
			byte_cnt <= '0;
			gap_cnt  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (word_valid) begin
						tx_en    <= 1'b1;
						txd      <= word.kind ? HDR_AUX : HDR_VIDEO;  // Header first
						byte_cnt <= word.kind ? BCNT_W'(AUX_BYTES) : BCNT_W'(VIDEO_BYTES);
						state    <= ST_SEND;
					end
				end
				ST_SEND: begin
					txd      <= shift[47:40];  // MSB first
					byte_cnt <= byte_cnt - 1'b1;
					if (byte_cnt == BCNT_W'(1)) begin
						gap_cnt <= GAP_W'(IFG_CYCLES - 1);
						state   <= ST_GAP;
					end
				end
				ST_GAP: begin
					tx_en <= 1'b0;             // Last byte still on the port this cycle
					if (gap_cnt == '0) begin
						state <= ST_IDLE;
					end else begin
						gap_cnt <= gap_cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Payload shifter, aux word moved up to the top bytes
	always_ff @(posedge clk50m_bufg) begin
		if (word_valid && word_ready) begin
			shift <= word.kind ? {word.data[23:0], 24'd0} : word.data;
		end else if (state == ST_SEND) begin
			shift <= {shift[39:0], 8'd0};
		end
	end

endmodule

`default_nettype wire

/* design/hdmi_eth_pkg.sv */
`default_nettype none

package hdmi_eth_pkg;

	localparam int CNT_W = 12;                 // Line and frame counters

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pix_t;

	// Decoded stream as it comes out of the TMDS receiver
	typedef struct packed {
		logic        hsync;
		logic        vsync;
		logic        vde;                      // Video data period
		logic        ade;                      // Aux (audio) data period
		pix_t        pix;
		logic [11:0] aux;                      // Aux bits of the three channels
	} hdmi_in_t;

	typedef struct packed {
		logic [CNT_W-1:0] hcnt;
		logic [CNT_W-1:0] vcnt;
		logic             line_start;          // One cycle, hcnt just cleared
		logic             frame_start;         // One cycle, vcnt just cleared
	} line_pos_t;

	typedef struct packed {
		logic [11:0] vcnt;
		logic [11:0] index;                    // Pixel number inside the window
		pix_t        pix;
	} video_word_t;

	typedef struct packed {
		logic [11:0] hcnt;                     // Where the ade burst began
		logic [11:0] aux;
	} aux_word_t;

	typedef struct packed {
		logic        kind;                     // 0 video, 1 aux
		logic [47:0] data;                     // Aux sits in the low 24 bits
	} tx_word_t;

	// Frame layout on the byte port
	localparam logic [7:0] HDR_VIDEO   = 8'h55;
	localparam logic [7:0] HDR_AUX     = 8'hA5;
	localparam int         VIDEO_BYTES = 6;
	localparam int         AUX_BYTES   = 3;

endpackage

`default_nettype wire

/* design/hdmi_eth_tx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module hdmi_eth_tx_top import hdmi_eth_pkg::*; #(
	parameter logic [CNT_W-1:0] CAP_START  = 12'd220,
	parameter logic [CNT_W-1:0] CAP_END    = 12'd1420,
	parameter int               FIFO_DEPTH = 16,
	parameter int               IFG_CYCLES = 2
) (
	input  wire           clk50m_bufg,
	input  wire           RSTBTN,
	input  wire hdmi_in_t hdmi_in,
	output wire           tx_en,
	output wire [7:0]     txd,
	output wire           ovf_video,
	output wire           ovf_aux
);

	line_pos_t   line_pos;
	logic        video_wr_en;
	video_word_t video_word;                   // Capture to FIFO
	logic        aux_wr_en;
	aux_word_t   aux_word;
	logic        video_valid;
	video_word_t video_head;                   // FIFO head to arbiter
	logic        video_pop;
	logic        aux_valid;
	aux_word_t   aux_head;
	logic        aux_pop;
	logic        word_valid;
	tx_word_t    tx_word;
	logic        word_ready;

	//////////////////////////////////////////////////////////////////////
	// Timing and capture
	//////////////////////////////////////////////////////////////////////
	sync_timing sync_timing0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.hdmi_in     (hdmi_in),
		.line_pos    (line_pos)
	);

	video_capture #(
		.CAP_START (CAP_START),
		.CAP_END   (CAP_END)
	) video_capture0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.hdmi_in     (hdmi_in),
		.line_pos    (line_pos),
		.wr_en       (video_wr_en),
		.word        (video_word)
	);

	aux_capture aux_capture0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.hdmi_in     (hdmi_in),
		.line_pos    (line_pos),
		.wr_en       (aux_wr_en),
		.word        (aux_word)
	);

	//////////////////////////////////////////////////////////////////////
	// Word FIFOs, same module for both payloads
	//////////////////////////////////////////////////////////////////////
	word_fifo #(
		.payload_t  (video_word_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) video_fifo (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.wr_en       (video_wr_en),
		.wr_data     (video_word),
		.pop         (video_pop),
		.valid       (video_valid),
		.rd_data     (video_head),
		.ovf         (ovf_video)
	);

	word_fifo #(
		.payload_t  (aux_word_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) aux_fifo (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.wr_en       (aux_wr_en),
		.wr_data     (aux_word),
		.pop         (aux_pop),
		.valid       (aux_valid),
		.rd_data     (aux_head),
		.ovf         (ovf_aux)
	);

	//////////////////////////////////////////////////////////////////////
	// Shared transmit port
	//////////////////////////////////////////////////////////////////////
	tx_arbiter tx_arbiter0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.video_valid (video_valid),
		.video_data  (video_head),
		.video_pop   (video_pop),
		.aux_valid   (aux_valid),
		.aux_data    (aux_head),
		.aux_pop     (aux_pop),
		.word_valid  (word_valid),
		.word        (tx_word),
		.word_ready  (word_ready)
	);

	frame_sender #(
		.IFG_CYCLES (IFG_CYCLES)
	) frame_sender0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.word_valid  (word_valid),
		.word        (tx_word),
		.word_ready  (word_ready),
		.tx_en       (tx_en),
		.txd         (txd)
	);

endmodule

`default_nettype wire

/* design/sync_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_timing import hdmi_eth_pkg::*; (
	input  wire           clk50m_bufg,
	input  wire           RSTBTN,
	input  wire hdmi_in_t hdmi_in,
	output line_pos_t     line_pos
);

	logic hsync_q;                             // hsync one cycle back
	logic vsync_q;                             // vsync one cycle back
	logic hs_rise;
	logic vs_rise;

	// Rising edges seen against the previous sample
	assign hs_rise = hdmi_in.hsync & ~hsync_q;
	assign vs_rise = hdmi_in.vsync & ~vsync_q;

	//////////////////////////////////////////////////////////////////////
	// Horizontal and vertical counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q  <= 1'b0;
			vsync_q  <= 1'b0;
			line_pos <= '0;
		end else begin
			hsync_q <= hdmi_in.hsync;
			vsync_q <= hdmi_in.vsync;

			line_pos.line_start  <= hs_rise;   // Strobes line up with the cleared counts
			line_pos.frame_start <= vs_rise;

			if (hs_rise) begin
				line_pos.hcnt <= '0;
			end else begin
				line_pos.hcnt <= line_pos.hcnt + 1'b1;  // Free running inside the line
			end

			// vsync edge takes priority over the line step
			if (vs_rise) begin
				line_pos.vcnt <= '0;
			end else if (hs_rise) begin
				line_pos.vcnt <= line_pos.vcnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/tx_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_arbiter import hdmi_eth_pkg::*; (
	input  wire              clk50m_bufg,
	input  wire              RSTBTN,
	input  wire              video_valid,
	input  wire video_word_t video_data,
	output logic             video_pop,
	input  wire              aux_valid,
	input  wire aux_word_t   aux_data,
	output logic             aux_pop,
	output logic             word_valid,
	output tx_word_t         word,
	input  wire              word_ready
);

	logic last_grant;                          // 1 when aux was served last
	logic hold;                                // Offered word not yet taken
	logic hold_sel;                            // Grant to keep while holding
	logic sel;                                 // 0 video, 1 aux
	logic take;

	always_comb begin
		if (hold) begin
			sel = hold_sel;                    // Stay with the offered FIFO
		end else if (video_valid && aux_valid) begin
			sel = ~last_grant;                 // Round robin
		end else begin
			sel = aux_valid;
		end
	end

	always_comb begin
		word_valid = sel ? aux_valid : video_valid;
		word.kind  = sel;
		word.data  = sel ? {24'd0, aux_data} : video_data;  // Aux right aligned
	end

	assign take      = word_valid & word_ready;
	assign video_pop = take & ~sel;            // Pop in the transfer cycle
	assign aux_pop   = take & sel;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			last_grant <= 1'b1;                // Video goes first after reset
			hold       <= 1'b0;
			hold_sel   <= 1'b0;
		end else begin
			hold     <= word_valid & ~word_ready;
			hold_sel <= sel;
			if (take) begin
				last_grant <= sel;
			end
		end
	end

endmodule

`default_nettype wire

/* design/video_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module video_capture import hdmi_eth_pkg::*; #(
	parameter logic [CNT_W-1:0] CAP_START = 12'd220,   // First hcnt inside the window
	parameter logic [CNT_W-1:0] CAP_END   = 12'd1420   // First hcnt past the window
) (
	input  wire            clk50m_bufg,
	input  wire            RSTBTN,
	input  wire hdmi_in_t  hdmi_in,
	input  wire line_pos_t line_pos,
	output logic           wr_en,
	output video_word_t    word
);

	logic [CNT_W-1:0] index;                   // Pixels taken so far on this line
	logic [CNT_W-1:0] index_cur;               // Index the current pixel gets
	logic             hit;

	// Active pixel inside the horizontal window
	assign hit = hdmi_in.vde
		&& (line_pos.hcnt >= CAP_START)
		&& (line_pos.hcnt < CAP_END);

	assign index_cur = line_pos.line_start ? '0 : index;  // New line restarts at 0

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_en <= 1'b0;
			index <= '0;
		end else begin
			wr_en <= hit;
			if (hit) begin
				index <= index_cur + 1'b1;
			end else begin
				index <= index_cur;
			end
		end
	end

	// Word register, loaded only on a captured pixel
	always_ff @(posedge clk50m_bufg) begin
		if (hit) begin
			word.vcnt  <= line_pos.vcnt;
			word.index <= index_cur;
			word.pix   <= hdmi_in.pix;
		end
	end

endmodule

`default_nettype wire

/* design/word_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module word_fifo #(
	parameter type payload_t  = logic [7:0],
	parameter int  FIFO_DEPTH = 16
) (
	input  wire           clk50m_bufg,
	input  wire           RSTBTN,
	input  wire           wr_en,
	input  wire payload_t wr_data,
	input  wire           pop,
	output logic          valid,               // FIFO not empty
	output payload_t      rd_data,             // Head word
	output logic          ovf                  // Sticky, write met a full FIFO
);

	localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

	payload_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [FILL_W-1:0] fill;                   // Words currently stored
	logic              full;
	logic              do_wr;
	logic              do_rd;

	// Wrap at FIFO_DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full    = (fill == FILL_W'(FIFO_DEPTH));
	assign valid   = (fill != '0);
	assign do_wr   = wr_en & ~full;            // Word dropped when full
	assign do_rd   = pop & valid;
	assign rd_data = mem[rd_ptr];              // Head shows the cycle after the write

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
			ovf    <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;         // Both or neither
			endcase
			if (wr_en && full) begin
				ovf <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

	// Expected words, tagged with the clock edge that sampled their input
	typedef struct packed {
		logic [31:0] cyc;
		video_word_t word;
	} exp_video_t;

	typedef struct packed {
		logic [31:0] cyc;
		aux_word_t   word;
	} exp_aux_t;

	exp_video_t       video_q[$];
	exp_aux_t         aux_q[$];

	line_pos_t        ref_pos;                 // Counts as the DUT registers them
	logic             ref_hsync_q;
	logic             ref_vsync_q;
	logic             ref_ade_q;
	logic [CNT_W-1:0] ref_index;               // Pixels taken on the current line
	logic [CNT_W-1:0] ref_burst_hcnt;          // Start of the running ade burst

	function automatic video_word_t build_video_word(input logic [11:0] vcnt,
			input logic [11:0] index, input pix_t pix);
		video_word_t w;
		w.vcnt  = vcnt;
		w.index = index;
		w.pix   = pix;
		return w;
	endfunction

	function automatic aux_word_t build_aux_word(input logic [11:0] hcnt, input logic [11:0] aux);
		aux_word_t w;
		w.hcnt = hcnt;
		w.aux  = aux;
		return w;
	endfunction

	task automatic reset_model();
		video_q.delete();
		aux_q.delete();
		ref_pos        = '0;
		ref_hsync_q    = 1'b0;
		ref_vsync_q    = 1'b0;
		ref_ade_q      = 1'b0;
		ref_index      = '0;
		ref_burst_hcnt = '0;
	endtask

	// One clock edge of the core; smp_cyc is the edge that samples this input
	task automatic step_model(input hdmi_in_t in, input logic [31:0] smp_cyc);
		logic [CNT_W-1:0] idx;
		logic             hs_rise;
		logic             vs_rise;
		exp_video_t       ev;
		exp_aux_t         ea;
		// Capture sees the counts from earlier cycles
		idx = ref_pos.line_start ? '0 : ref_index;
		if (in.vde && ref_pos.hcnt >= CAP_START && ref_pos.hcnt < CAP_END) begin
			ev.cyc  = smp_cyc;
			ev.word = build_video_word(ref_pos.vcnt, idx, in.pix);
			video_q.push_back(ev);
			idx = idx + 1'b1;
		end
		ref_index = idx;
		if (in.ade) begin
			if (!ref_ade_q) begin
				ref_burst_hcnt = ref_pos.hcnt;     // First cycle of the burst
			end
			ea.cyc  = smp_cyc;
			ea.word = build_aux_word(ref_burst_hcnt, in.aux);
			aux_q.push_back(ea);
		end
		ref_ade_q = in.ade;
		// Counter rule, vsync edge beats hsync edge
		hs_rise = in.hsync & ~ref_hsync_q;
		vs_rise = in.vsync & ~ref_vsync_q;
		ref_pos.line_start  = hs_rise;
		ref_pos.frame_start = vs_rise;
		ref_pos.hcnt = hs_rise ? '0 : ref_pos.hcnt + 1'b1;
		if (vs_rise) begin
			ref_pos.vcnt = '0;
		end else if (hs_rise) begin
			ref_pos.vcnt = ref_pos.vcnt + 1'b1;
		end
		ref_hsync_q = in.hsync;
		ref_vsync_q = in.vsync;
	endtask

`endif

/* testbench/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top import hdmi_eth_pkg::*; ;

	localparam logic [CNT_W-1:0] CAP_START = 12'd4;
	localparam logic [CNT_W-1:0] CAP_END   = 12'd12;
	localparam int FIFO_DEPTH      = 16;
	localparam int IFG_CYCLES      = 2;
	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 5;
	localparam int LINE_CYCLES     = 100;
	localparam int LINES_PER_FRAME = 8;
	localparam int N_FRAMES        = 3;
	localparam int VDE_FIRST       = 2;    // Line cycles with vde high
	localparam int VDE_LAST        = 15;
	localparam int DRAIN_CYCLES    = 400;  // Margin for the FIFOs to empty

	logic        clk50m_bufg = 1'b0;
	logic        RSTBTN      = 1'b1;
	hdmi_in_t    hdmi_in     = '0;
	wire         tx_en;
	wire [7:0]   txd;
	wire         ovf_video;
	wire         ovf_aux;

	logic [31:0] cyc = '0;                 // Rising edges so far
	logic [31:0] rng_state = 32'd5;
	int          hits_per_line;            // Window hits worked out from the line layout
	int          aux_total = 0;            // ade cycles driven

	// Frame collector state
	logic        in_frame = 1'b0;
	logic        frame_kind;
	logic        prev_kind;
	logic        prev_other_waiting;
	logic [47:0] payload;
	int          nbytes;
	int          low_cnt = 0;
	int          frames_seen = 0;
	int          video_frames = 0;
	int          aux_frames = 0;
	logic [11:0] group_vcnt;
	int          group_cnt = 0;

	`include "tb_model.svh"

	hdmi_eth_tx_top #(
		.CAP_START  (CAP_START),
		.CAP_END    (CAP_END),
		.FIFO_DEPTH (FIFO_DEPTH),
		.IFG_CYCLES (IFG_CYCLES)
	) dut0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.hdmi_in     (hdmi_in),
		.tx_en       (tx_en),
		.txd         (txd),
		.ovf_video   (ovf_video),
		.ovf_aux     (ovf_aux)
	);

	always #(CLK_PERIOD / 2) clk50m_bufg = ~clk50m_bufg;

	always @(posedge clk50m_bufg) cyc <= cyc + 1'b1;

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic compare_values(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Called on a falling edge and returns on the next one
	task automatic apply_cycle(input hdmi_in_t in);
		hdmi_in = in;
		step_model(in, cyc + 1'b1);
		@(negedge clk50m_bufg);
	endtask

	task automatic drive_line(input int line_in_frame);
		hdmi_in_t    in;
		logic [31:0] r;
		logic        has_burst;
		int          burst_start;
		int          burst_len;
		r           = next_random();
		has_burst   = r[20] | r[21];               // Most lines carry a burst
		burst_len   = 1 + r[17:16];
		burst_start = 40 + (r[27:22] % 18);        // Ends by cycle 60
		if (has_burst) begin
			aux_total += burst_len;
		end
		for (int c = 0; c < LINE_CYCLES; c++) begin
			in       = '0;
			in.hsync = (c < 4);
			in.vsync = (line_in_frame == 0);
			in.vde   = (c >= VDE_FIRST) && (c <= VDE_LAST);
			in.ade   = has_burst && (c >= burst_start) && (c < burst_start + burst_len);
			r        = next_random();
			in.pix   = r[31:8];
			r        = next_random();
			in.aux   = r[31:20];
			apply_cycle(in);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame collector
	//////////////////////////////////////////////////////////////////////
	task automatic start_frame();
		logic other_waiting;
		if (frames_seen != 0 && low_cnt < IFG_CYCLES) begin
			$display("error at %0d ns: tx_en was low for only %0d cycles between frames",
				$time, low_cnt);
			abort_run();
		end
		if (txd !== HDR_VIDEO && txd !== HDR_AUX) begin
			$display("error at %0d ns: frame header %02h is neither the video nor the aux header",
				$time, txd);
			abort_run();
		end
		frame_kind = (txd == HDR_AUX);
		// Other word written early enough to be seen by the arbiter
		if (frame_kind) begin
			other_waiting = (video_q.size() != 0) && (video_q[0].cyc < cyc);
		end else begin
			other_waiting = (aux_q.size() != 0) && (aux_q[0].cyc < cyc);
		end
		if (frames_seen != 0 && frame_kind == prev_kind && prev_other_waiting) begin
			$display("two frames of one kind in a row while the other FIFO had a word");
			abort_run();
		end
		prev_kind          = frame_kind;
		prev_other_waiting = other_waiting;
		in_frame           = 1'b1;
		nbytes             = 0;
		payload            = '0;
		frames_seen++;
	endtask

	task automatic finish_frame();
		exp_video_t  ev;
		exp_aux_t    ea;
		video_word_t got_v;
		aux_word_t   got_a;
		if (frame_kind) begin
			compare_values(nbytes, AUX_BYTES, "aux payload length");
			if (aux_q.size() == 0) begin
				$display("an aux frame arrived with no aux word expected");
				abort_run();
			end
			ea    = aux_q.pop_front();
			got_a = payload[23:0];
			compare_values(got_a.hcnt, ea.word.hcnt, "aux burst start hcnt");
			compare_values(got_a.aux, ea.word.aux, "aux bits");
			aux_frames++;
		end else begin
			compare_values(nbytes, VIDEO_BYTES, "video payload length");
			if (video_q.size() == 0) begin
				$display("a video frame arrived with no video word expected");
				abort_run();
			end
			ev    = video_q.pop_front();
			got_v = payload;
			compare_values(got_v.vcnt, ev.word.vcnt, "video vcnt");
			compare_values(got_v.index, ev.word.index, "video index");
			compare_values(got_v.pix, ev.word.pix, "video rgb");
			// Line grouping, index run and vcnt wrap
			if (video_frames == 0) begin
				compare_values(got_v.vcnt, 0, "vcnt of first line");
				compare_values(got_v.index, 0, "index of first pixel");
				group_cnt = 1;
			end else if (got_v.vcnt == group_vcnt) begin
				compare_values(got_v.index, group_cnt, "index inside line");
				group_cnt++;
			end else begin
				compare_values(group_cnt, hits_per_line, "video words per line");
				compare_values(got_v.vcnt, (group_vcnt + 1) % LINES_PER_FRAME, "next vcnt");
				compare_values(got_v.index, 0, "index after line start");
				group_cnt = 1;
			end
			group_vcnt = got_v.vcnt;
			video_frames++;
		end
	endtask

	always @(negedge clk50m_bufg) begin
		compare_values(ovf_video, 1'b0, "ovf_video");
		compare_values(ovf_aux, 1'b0, "ovf_aux");
		if (tx_en === 1'b1) begin
			if (!in_frame) begin
				start_frame();                     // Rising tx_en brings the header byte
			end else begin
				payload = {payload[39:0], txd};    // MSB first
				nbytes++;
			end
			low_cnt = 0;
		end else begin
			if (in_frame) begin
				finish_frame();
				in_frame = 1'b0;
			end
			low_cnt++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and end of run
	//////////////////////////////////////////////////////////////////////
	initial begin
		reset_model();
		hits_per_line = 0;
		for (int c = 0; c < LINE_CYCLES; c++) begin
			// Counts lag the input by one cycle so hcnt is 0 on cycle 1
			if (c >= VDE_FIRST && c <= VDE_LAST && c - 1 >= CAP_START && c - 1 < CAP_END) begin
				hits_per_line++;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk50m_bufg);
		@(negedge clk50m_bufg);
		RSTBTN = 1'b0;
		compare_values(tx_en, 1'b0, "tx_en after reset");
		for (int f = 0; f < N_FRAMES; f++) begin
			for (int l = 0; l < LINES_PER_FRAME; l++) begin
				drive_line(l);
			end
		end
		while (video_q.size() != 0 || aux_q.size() != 0 || in_frame) begin
			apply_cycle('0);
		end
		repeat (20) apply_cycle('0);           // No stray frames afterwards
		compare_values(video_frames, N_FRAMES * LINES_PER_FRAME * hits_per_line, "video frames");
		compare_values(aux_frames, aux_total, "aux frames");
		compare_values(group_cnt, hits_per_line, "video words in last line");
		$display("SIMULATION PASSED");
		$finish;
	end

	// Watchdog sized from the stimulus length
	initial begin
		#((RESET_CYCLES + N_FRAMES * LINES_PER_FRAME * LINE_CYCLES + DRAIN_CYCLES) * CLK_PERIOD);
		$display("timeout, the expected frames were not all sent in time");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
